//--- files.f
+incdir+tests
common/hart_pkg.sv
hw/fetch_unit.sv
hw/hazard_unit.sv
hw/decode/reg_file.sv
hw/decode/decoder.sv
hw/execute_unit.sv
hw/mem_wb_unit.sv
hw/hart.sv
tests/hart_tb.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module hart_tb -f files.f

sim:
	verilator --binary --timing -j 0 --top-module hart_tb -Mdir $(OBJ_DIR) -f files.f
	./$(OBJ_DIR)/Vhart_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/hart_tb_program.svh
initial begin
  // one row per instruction word at pc = RESET_ADDR + 4 * row
  // columns: instruction, skipped by a taken branch or jump, rd, rd value, next pc
  prog[0]  = '{32'h00500093, 1'b0, 5'd1,  32'h00000005, 32'h00000004};  // addi x1,x0,5
  prog[1]  = '{32'hFFD08113, 1'b0, 5'd2,  32'h00000002, 32'h00000008};  // addi x2,x1,-3
  prog[2]  = '{32'h002081B3, 1'b0, 5'd3,  32'h00000007, 32'h0000000C};  // add x3,x1,x2
  prog[3]  = '{32'h40110233, 1'b0, 5'd4,  32'hFFFFFFFD, 32'h00000010};  // sub x4,x2,x1
  prog[4]  = '{32'h123452B7, 1'b0, 5'd5,  32'h12345000, 32'h00000014};  // lui x5,0x12345
  prog[5]  = '{32'h00001317, 1'b0, 5'd6,  32'h00001014, 32'h00000018};  // auipc x6,1
  prog[6]  = '{32'h002093B3, 1'b0, 5'd7,  32'h00000014, 32'h0000001C};  // sll x7,x1,x2
  prog[7]  = '{32'h40125413, 1'b0, 5'd8,  32'hFFFFFFFE, 32'h00000020};  // srai x8,x4,1
  prog[8]  = '{32'h01C25493, 1'b0, 5'd9,  32'h0000000F, 32'h00000024};  // srli x9,x4,28
  prog[9]  = '{32'h00122533, 1'b0, 5'd10, 32'h00000001, 32'h00000028};  // slt x10,x4,x1
  prog[10] = '{32'h001235B3, 1'b0, 5'd11, 32'h00000000, 32'h0000002C};  // sltu x11,x4,x1
  prog[11] = '{32'h0FF1C613, 1'b0, 5'd12, 32'h000000F8, 32'h00000030};  // xori x12,x3,0xff
  prog[12] = '{32'h0032E6B3, 1'b0, 5'd13, 32'h12345007, 32'h00000034};  // or x13,x5,x3
  prog[13] = '{32'h0066F733, 1'b0, 5'd14, 32'h00001004, 32'h00000038};  // and x14,x13,x6
  prog[14] = '{32'h00108013, 1'b0, 5'd0,  32'h00000000, 32'h0000003C};  // addi x0,x1,1
  prog[15] = '{32'h001007B3, 1'b0, 5'd15, 32'h00000005, 32'h00000040};  // add x15,x0,x1
  prog[16] = '{32'h00302423, 1'b0, 5'd0,  32'h00000000, 32'h00000044};  // sw x3,8(x0)
  prog[17] = '{32'h00A02803, 1'b0, 5'd16, 32'h00000007, 32'h00000048};  // lw x16,10(x0)
  prog[18] = '{32'h010808B3, 1'b0, 5'd17, 32'h0000000E, 32'h0000004C};  // add x17,x16,x16
  prog[19] = '{32'h00108463, 1'b0, 5'd0,  32'h00000000, 32'h00000054};  // beq taken
  prog[20] = '{32'h06300913, 1'b1, 5'd18, 32'h00000063, 32'h00000054};  // passed over
  prog[21] = '{32'h00109463, 1'b0, 5'd0,  32'h00000000, 32'h00000058};  // bne not taken
  prog[22] = '{32'h00124463, 1'b0, 5'd0,  32'h00000000, 32'h00000060};  // blt taken, signed
  prog[23] = '{32'h06300913, 1'b1, 5'd18, 32'h00000063, 32'h00000060};  // passed over
  prog[24] = '{32'h00127463, 1'b0, 5'd0,  32'h00000000, 32'h00000068};  // bgeu taken
  prog[25] = '{32'h06300913, 1'b1, 5'd18, 32'h00000063, 32'h00000068};  // passed over
  prog[26] = '{32'h008009EF, 1'b0, 5'd19, 32'h0000006C, 32'h00000070};  // jal x19,+8
  prog[27] = '{32'h06300913, 1'b1, 5'd18, 32'h00000063, 32'h00000070};  // passed over
  prog[28] = '{32'h07D00A13, 1'b0, 5'd20, 32'h0000007D, 32'h00000074};  // addi x20,x0,125
  prog[29] = '{32'h000A0AE7, 1'b0, 5'd21, 32'h00000078, 32'h0000007C};  // jalr, bit 0 cleared
  prog[30] = '{32'h06300913, 1'b1, 5'd18, 32'h00000063, 32'h0000007C};  // passed over
  prog[31] = '{32'h00100073, 1'b0, 5'd0,  32'h00000000, 32'h00000080};  // ebreak
end

//--- tests/hart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module hart_tb;

  localparam logic [31:0] RESET_ADDR = 32'h0;
  localparam int          NUM_ROWS   = 32;
  localparam int          MAX_CYCLES = NUM_ROWS * 7 + 20;  // worst case stall per row plus fill
  localparam logic [31:0] NOP_INST   = 32'h00000013;

  typedef struct {
    logic [31:0] inst;
    logic        skip;     // a taken branch or jump passes over this row
    logic [4:0]  rd;
    logic [31:0] rd_val;
    logic [31:0] next_pc;
  } row_t;

  row_t prog [NUM_ROWS];

  `include "hart_tb_program.svh"

  logic        i_clk;
  logic        i_rst;
  logic [31:0] o_imem_raddr;
  logic [31:0] i_imem_rdata;
  logic [31:0] o_dmem_addr;
  logic        o_dmem_ren;
  logic        o_dmem_wen;
  logic [31:0] o_dmem_wdata;
  logic [31:0] i_dmem_rdata;
  logic        o_retire_valid;
  logic [31:0] o_retire_inst;
  logic [31:0] o_retire_pc;
  logic [31:0] o_retire_next_pc;
  logic [4:0]  o_retire_rd_waddr;
  logic [31:0] o_retire_rd_wdata;
  logic        o_retire_halt;

  logic [31:0] dmem [64];
  int          cycles;
  int          retire_count;  // counted on its own, apart from the table walk

  hart #(.RESET_ADDR(RESET_ADDR)) DUT (.*);

  always #2 i_clk = ~i_clk;

  // instruction memory answers at once, past the table it returns nops
  assign i_imem_rdata = ((o_imem_raddr - RESET_ADDR) >> 2) < NUM_ROWS ?
                        prog[(o_imem_raddr - RESET_ADDR) >> 2].inst : NOP_INST;
  // the data memory only drives a word while the read enable is high
  assign i_dmem_rdata = (o_dmem_ren === 1'b1) ? dmem[o_dmem_addr[7:2]] : 32'h0;

  always @(posedge i_clk) begin
    if (o_dmem_wen === 1'b1) begin
      dmem[o_dmem_addr[7:2]] <= o_dmem_wdata;
    end
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
    end
  endtask

  task automatic wait_retire();
    do begin
      @(negedge i_clk);
    end while (o_retire_valid !== 1'b1);
  endtask

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_now("timeout, program did not halt");
    end
    if (!i_rst && o_retire_valid === 1'b1) begin
      retire_count <= retire_count + 1;
    end
  end

  // side checks sampled in the middle of the cycle, away from the clock edge
  always @(negedge i_clk) begin
    if (i_rst) begin
      assert (o_retire_valid === 1'b0) else fail_now("retire valid high during reset");
    end
    if (retire_count == 0 && o_retire_valid !== 1'b1) begin
      assert (o_dmem_ren === 1'b0 && o_dmem_wen === 1'b0)
        else fail_now("data memory enabled before the first retire");
    end
    if (o_dmem_ren === 1'b1 || o_dmem_wen === 1'b1) begin
      assert (o_dmem_addr[1:0] === 2'b00) else fail_now("data memory address not word aligned");
    end
  end

  initial begin
    int expected_retires;
    logic [31:0] exp_pc;
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    cycles       <= 0;
    retire_count <= 0;
    expected_retires = 0;
    for (int a = 0; a < 64; a++) begin
      dmem[a] <= 32'hD0D00000 ^ (a * 32'h00010101);  // every word differs
    end
    repeat (3) @(posedge i_clk);
    #1 i_rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (!prog[i].skip) begin
        exp_pc = RESET_ADDR + 32'(i) * 32'd4;
        wait_retire();
        expected_retires++;
        check_word($sformatf("row %0d pc", i), exp_pc, o_retire_pc);
        check_word($sformatf("row %0d inst", i), prog[i].inst, o_retire_inst);
        check_word($sformatf("row %0d rd", i), 32'(prog[i].rd), 32'(o_retire_rd_waddr));
        if (prog[i].rd != 5'd0) begin
          check_word($sformatf("row %0d rd data", i), prog[i].rd_val, o_retire_rd_wdata);
        end
        check_word($sformatf("row %0d next pc", i), prog[i].next_pc, o_retire_next_pc);
        // only the final row, the ebreak, halts
        check_word($sformatf("row %0d halt", i), 32'(i == NUM_ROWS - 1),
                   32'(o_retire_halt));
      end
    end

    // let the counter take in the last retire
    @(posedge i_clk);
    #1;
    assert (retire_count == expected_retires) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("[FAIL] retire count expected %0d actual %0d", expected_retires, retire_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
    end
  end

endmodule

`default_nettype wire

//--- hw/hart.sv
`timescale 1ns/10ps
`default_nettype none

module hart #(
  parameter hart_pkg::word_t RESET_ADDR = '0  // first fetch address, must be word aligned
) (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  output logic [31:0]              o_imem_raddr,
  input  wire hart_pkg::word_t     i_imem_rdata,
  output hart_pkg::word_t          o_dmem_addr,
  output logic                     o_dmem_ren,
  output logic                     o_dmem_wen,
  output hart_pkg::word_t          o_dmem_wdata,
  input  wire hart_pkg::word_t     i_dmem_rdata,
  output logic                     o_retire_valid,
  output hart_pkg::word_t          o_retire_inst,
  output hart_pkg::word_t          o_retire_pc,
  output hart_pkg::word_t          o_retire_next_pc,
  output hart_pkg::reg_addr_t      o_retire_rd_waddr,
  output hart_pkg::word_t          o_retire_rd_wdata,
  output logic                     o_retire_halt
);
  import hart_pkg::*;

  // fetch to decode
  word_t     id_pc;
  word_t     id_inst;
  logic      id_valid;
  logic      stall;
  logic      redirect;  // one-cycle strobe from execute
  word_t     redirect_pc;

  // register file traffic
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs1_used;
  logic      rs2_used;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rf_waddr;
  logic      rf_wen;
  word_t     rf_wdata;

  // decode to execute
  logic      ex_valid;
  word_t     ex_pc;
  word_t     ex_inst;
  word_t     ex_op1;
  word_t     ex_op2;
  word_t     ex_store_data;
  word_t     ex_imm;
  reg_addr_t ex_rd;
  logic      ex_wen;
  logic      ex_ren_mem;
  logic      ex_wen_mem;
  alu_op_e   ex_alu_op;
  wb_sel_e   ex_wb_sel;
  logic      ex_branch;
  logic      ex_jal;
  logic      ex_jalr;
  logic [2:0] ex_funct3;
  logic      ex_halt;

  // execute to memory
  logic      mem_valid;
  word_t     mem_pc;
  word_t     mem_inst;
  word_t     mem_result;
  word_t     mem_store_data;
  word_t     mem_next_pc;
  reg_addr_t mem_rd;
  logic      mem_wen;
  logic      mem_ren_mem;
  logic      mem_wen_mem;
  wb_sel_e   mem_wb_sel;
  logic      mem_halt;

  fetch_unit #(.RESET_ADDR(RESET_ADDR)) u_fetch (
    .i_clk, .i_rst, .i_stall(stall), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .i_imem_rdata, .o_imem_raddr, .o_id_pc(id_pc), .o_id_inst(id_inst), .o_id_valid(id_valid)
  );

  hazard_unit u_hazard (
    .i_rs1(rs1), .i_rs2(rs2), .i_rs1_used(rs1_used), .i_rs2_used(rs2_used),
    .i_id_valid(id_valid), .i_ex_rd(ex_rd), .i_ex_wen(ex_wen), .i_mem_rd(mem_rd),
    .i_mem_wen(mem_wen), .o_stall(stall)
  );

  decoder u_decoder (
    .i_clk, .i_rst, .i_stall(stall), .i_flush(redirect), .i_pc(id_pc), .i_inst(id_inst),
    .i_valid(id_valid), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_rs1(rs1), .o_rs2(rs2), .o_rs1_used(rs1_used), .o_rs2_used(rs2_used),
    .o_ex_valid(ex_valid), .o_ex_pc(ex_pc), .o_ex_inst(ex_inst), .o_ex_op1(ex_op1),
    .o_ex_op2(ex_op2), .o_ex_store_data(ex_store_data), .o_ex_imm(ex_imm), .o_ex_rd(ex_rd),
    .o_ex_wen(ex_wen), .o_ex_ren_mem(ex_ren_mem), .o_ex_wen_mem(ex_wen_mem),
    .o_ex_alu_op(ex_alu_op), .o_ex_wb_sel(ex_wb_sel), .o_ex_branch(ex_branch),
    .o_ex_jal(ex_jal), .o_ex_jalr(ex_jalr), .o_ex_funct3(ex_funct3), .o_ex_halt(ex_halt)
  );

  reg_file u_reg_file (
    .i_clk, .i_rst, .i_rs1_raddr(rs1), .i_rs2_raddr(rs2), .i_rd_waddr(rf_waddr),
    .i_rd_wen(rf_wen), .i_rd_wdata(rf_wdata), .o_rs1_rdata(rs1_data), .o_rs2_rdata(rs2_data)
  );

  execute_unit u_execute (
    .i_clk, .i_rst, .i_ex_valid(ex_valid), .i_ex_pc(ex_pc), .i_ex_inst(ex_inst),
    .i_ex_op1(ex_op1), .i_ex_op2(ex_op2), .i_ex_store_data(ex_store_data), .i_ex_imm(ex_imm),
    .i_ex_rd(ex_rd), .i_ex_wen(ex_wen), .i_ex_ren_mem(ex_ren_mem), .i_ex_wen_mem(ex_wen_mem),
    .i_ex_alu_op(ex_alu_op), .i_ex_wb_sel(ex_wb_sel), .i_ex_branch(ex_branch),
    .i_ex_jal(ex_jal), .i_ex_jalr(ex_jalr), .i_ex_funct3(ex_funct3), .i_ex_halt(ex_halt),
    .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_mem_valid(mem_valid), .o_mem_pc(mem_pc), .o_mem_inst(mem_inst),
    .o_mem_result(mem_result), .o_mem_store_data(mem_store_data),
    .o_mem_next_pc(mem_next_pc), .o_mem_rd(mem_rd), .o_mem_wen(mem_wen),
    .o_mem_ren_mem(mem_ren_mem), .o_mem_wen_mem(mem_wen_mem), .o_mem_wb_sel(mem_wb_sel),
    .o_mem_halt(mem_halt)
  );

  mem_wb_unit u_mem_wb (
    .i_clk, .i_rst, .i_mem_valid(mem_valid), .i_mem_pc(mem_pc), .i_mem_inst(mem_inst),
    .i_mem_result(mem_result), .i_mem_store_data(mem_store_data),
    .i_mem_next_pc(mem_next_pc), .i_mem_rd(mem_rd), .i_mem_wen(mem_wen),
    .i_mem_ren_mem(mem_ren_mem), .i_mem_wen_mem(mem_wen_mem), .i_mem_wb_sel(mem_wb_sel),
    .i_mem_halt(mem_halt), .i_dmem_rdata,
    .o_dmem_addr, .o_dmem_wdata, .o_dmem_ren, .o_dmem_wen,
    .o_rf_waddr(rf_waddr), .o_rf_wen(rf_wen), .o_rf_wdata(rf_wdata),
    .o_retire_valid, .o_retire_inst, .o_retire_pc, .o_retire_next_pc,
    .o_retire_rd_waddr, .o_retire_rd_wdata, .o_retire_halt
  );

endmodule

`default_nettype wire

//--- hw/mem_wb_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_unit (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_mem_valid,
  input  wire hart_pkg::word_t     i_mem_pc,
  input  wire hart_pkg::word_t     i_mem_inst,
  input  wire hart_pkg::word_t     i_mem_result,
  input  wire hart_pkg::word_t     i_mem_store_data,
  input  wire hart_pkg::word_t     i_mem_next_pc,
  input  wire hart_pkg::reg_addr_t i_mem_rd,
  input  wire logic                i_mem_wen,
  input  wire logic                i_mem_ren_mem,
  input  wire logic                i_mem_wen_mem,
  input  wire hart_pkg::wb_sel_e   i_mem_wb_sel,
  input  wire logic                i_mem_halt,
  input  wire hart_pkg::word_t     i_dmem_rdata,
  output hart_pkg::word_t          o_dmem_addr,
  output hart_pkg::word_t          o_dmem_wdata,
  output logic                     o_dmem_ren,
  output logic                     o_dmem_wen,
  output hart_pkg::reg_addr_t      o_rf_waddr,
  output logic                     o_rf_wen,
  output hart_pkg::word_t          o_rf_wdata,
  output logic                     o_retire_valid,
  output hart_pkg::word_t          o_retire_inst,
  output hart_pkg::word_t          o_retire_pc,
  output hart_pkg::word_t          o_retire_next_pc,
  output hart_pkg::reg_addr_t      o_retire_rd_waddr,
  output hart_pkg::word_t          o_retire_rd_wdata,
  output logic                     o_retire_halt
);
  import hart_pkg::*;

  logic      wb_valid;
  logic      wb_wen;
  logic      wb_halt;
  reg_addr_t wb_rd;
  wb_sel_e   wb_sel;
  word_t     wb_result;
  word_t     wb_load_data;  // captured in the memory stage, memory answers combinationally
  word_t     wb_pc;
  word_t     wb_inst;
  word_t     wb_next_pc;
  word_t     wb_data;

  assign o_dmem_addr  = {i_mem_result[XLEN-1:2], 2'b00};  // word accesses only
  assign o_dmem_wdata = i_mem_store_data;
  assign o_dmem_ren   = i_mem_valid && i_mem_ren_mem;
  assign o_dmem_wen   = i_mem_valid && i_mem_wen_mem;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid <= 1'b0;
      wb_wen   <= 1'b0;
      wb_halt  <= 1'b0;
    end else begin
      wb_valid <= i_mem_valid;
      wb_wen   <= i_mem_wen;
      wb_halt  <= i_mem_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_rd        <= i_mem_rd;
    wb_sel       <= i_mem_wb_sel;
    wb_result    <= i_mem_result;
    wb_load_data <= i_dmem_rdata;
    wb_pc        <= i_mem_pc;
    wb_inst      <= i_mem_inst;
    wb_next_pc   <= i_mem_next_pc;
  end

  always_comb begin
    case (wb_sel)
      wb_load: wb_data = wb_load_data;
      wb_pc4:  wb_data = wb_pc + 32'd4;  // link address
      default: wb_data = wb_result;
    endcase
  end

  assign o_rf_waddr = wb_rd;
  assign o_rf_wen   = wb_valid && wb_wen;
  assign o_rf_wdata = wb_data;

  // the retire record mirrors what the register file sees this cycle
  assign o_retire_valid    = wb_valid && !i_rst;
  assign o_retire_inst     = wb_inst;
  assign o_retire_pc       = wb_pc;
  assign o_retire_next_pc  = wb_next_pc;
  assign o_retire_rd_waddr = wb_rd;
  assign o_retire_rd_wdata = wb_data;
  assign o_retire_halt     = wb_halt;

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_ex_valid,
  input  wire hart_pkg::word_t     i_ex_pc,
  input  wire hart_pkg::word_t     i_ex_inst,
  input  wire hart_pkg::word_t     i_ex_op1,
  input  wire hart_pkg::word_t     i_ex_op2,
  input  wire hart_pkg::word_t     i_ex_store_data,
  input  wire hart_pkg::word_t     i_ex_imm,
  input  wire hart_pkg::reg_addr_t i_ex_rd,
  input  wire logic                i_ex_wen,
  input  wire logic                i_ex_ren_mem,
  input  wire logic                i_ex_wen_mem,
  input  wire hart_pkg::alu_op_e   i_ex_alu_op,
  input  wire hart_pkg::wb_sel_e   i_ex_wb_sel,
  input  wire logic                i_ex_branch,
  input  wire logic                i_ex_jal,
  input  wire logic                i_ex_jalr,
  input  wire logic [2:0]          i_ex_funct3,
  input  wire logic                i_ex_halt,
  output logic                     o_redirect,
  output hart_pkg::word_t          o_redirect_pc,
  output logic                     o_mem_valid,
  output hart_pkg::word_t          o_mem_pc,
  output hart_pkg::word_t          o_mem_inst,
  output hart_pkg::word_t          o_mem_result,
  output hart_pkg::word_t          o_mem_store_data,
  output hart_pkg::word_t          o_mem_next_pc,
  output hart_pkg::reg_addr_t      o_mem_rd,
  output logic                     o_mem_wen,
  output logic                     o_mem_ren_mem,
  output logic                     o_mem_wen_mem,
  output hart_pkg::wb_sel_e        o_mem_wb_sel,
  output logic                     o_mem_halt
);
  import hart_pkg::*;

  word_t alu_result;
  word_t target;
  logic  cond;  // branch condition from funct3

  always_comb begin
    case (i_ex_alu_op)
      alu_sub:  alu_result = i_ex_op1 - i_ex_op2;
      alu_and:  alu_result = i_ex_op1 & i_ex_op2;
      alu_or:   alu_result = i_ex_op1 | i_ex_op2;
      alu_xor:  alu_result = i_ex_op1 ^ i_ex_op2;
      alu_slt:  alu_result = {31'd0, $signed(i_ex_op1) < $signed(i_ex_op2)};
      alu_sltu: alu_result = {31'd0, i_ex_op1 < i_ex_op2};
      alu_sll:  alu_result = i_ex_op1 << i_ex_op2[4:0];  // only five shift bits count
      alu_srl:  alu_result = i_ex_op1 >> i_ex_op2[4:0];
      alu_sra:  alu_result = word_t'($signed(i_ex_op1) >>> i_ex_op2[4:0]);
      default:  alu_result = i_ex_op1 + i_ex_op2;
    endcase
  end

  always_comb begin
    case (i_ex_funct3)
      3'b000:  cond = (i_ex_op1 == i_ex_op2);
      3'b001:  cond = (i_ex_op1 != i_ex_op2);
      3'b100:  cond = ($signed(i_ex_op1) < $signed(i_ex_op2));
      3'b101:  cond = ($signed(i_ex_op1) >= $signed(i_ex_op2));
      3'b110:  cond = (i_ex_op1 < i_ex_op2);
      3'b111:  cond = (i_ex_op1 >= i_ex_op2);
      default: cond = 1'b0;
    endcase
  end

  // jalr reuses the alu sum of rs1 and immediate with bit 0 dropped
  assign target        = i_ex_jalr ? {alu_result[31:1], 1'b0} : i_ex_pc + i_ex_imm;
  assign o_redirect    = i_ex_valid && ((i_ex_branch && cond) || i_ex_jal || i_ex_jalr);
  assign o_redirect_pc = target;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_valid   <= 1'b0;
      o_mem_wen     <= 1'b0;
      o_mem_ren_mem <= 1'b0;
      o_mem_wen_mem <= 1'b0;
      o_mem_halt    <= 1'b0;
    end else begin
      o_mem_valid   <= i_ex_valid;
      o_mem_wen     <= i_ex_wen;
      o_mem_ren_mem <= i_ex_ren_mem;
      o_mem_wen_mem <= i_ex_wen_mem;
      o_mem_halt    <= i_ex_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    o_mem_pc         <= i_ex_pc;
    o_mem_inst       <= i_ex_inst;
    o_mem_result     <= alu_result;
    o_mem_store_data <= i_ex_store_data;
    o_mem_next_pc    <= o_redirect ? target : i_ex_pc + 32'd4;  // what retire reports
    o_mem_rd         <= i_ex_rd;
    o_mem_wb_sel     <= i_ex_wb_sel;
  end

endmodule

`default_nettype wire

//--- hw/decode/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_stall,
  input  wire logic                i_flush,   // redirect from execute
  input  wire hart_pkg::word_t     i_pc,
  input  wire hart_pkg::word_t     i_inst,
  input  wire logic                i_valid,
  input  wire hart_pkg::word_t     i_rs1_data,
  input  wire hart_pkg::word_t     i_rs2_data,
  output hart_pkg::reg_addr_t      o_rs1,
  output hart_pkg::reg_addr_t      o_rs2,
  output logic                     o_rs1_used,
  output logic                     o_rs2_used,
  output logic                     o_ex_valid,
  output hart_pkg::word_t          o_ex_pc,
  output hart_pkg::word_t          o_ex_inst,
  output hart_pkg::word_t          o_ex_op1,
  output hart_pkg::word_t          o_ex_op2,
  output hart_pkg::word_t          o_ex_store_data,
  output hart_pkg::word_t          o_ex_imm,
  output hart_pkg::reg_addr_t      o_ex_rd,
  output logic                     o_ex_wen,
  output logic                     o_ex_ren_mem,
  output logic                     o_ex_wen_mem,
  output hart_pkg::alu_op_e        o_ex_alu_op,
  output hart_pkg::wb_sel_e        o_ex_wb_sel,
  output logic                     o_ex_branch,
  output logic                     o_ex_jal,
  output logic                     o_ex_jalr,
  output logic [2:0]               o_ex_funct3,
  output logic                     o_ex_halt
);
  import hart_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;  // funct7 bit 5, picks sub and sra
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm;
  alu_op_e    alu_op;
  wb_sel_e    wb_sel;
  logic       wen;
  logic       ren_mem;
  logic       wen_mem;
  logic       branch;
  logic       jal;
  logic       jalr;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign alt    = i_inst[30];
  assign o_rs1  = i_inst[19:15];  // register file is read with the raw fields
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'd0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sub_sra ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    wen        = 1'b0;
    ren_mem    = 1'b0;
    wen_mem    = 1'b0;
    branch     = 1'b0;
    jal        = 1'b0;
    jalr       = 1'b0;
    o_rs1_used = 1'b0;
    o_rs2_used = 1'b0;
    alu_op     = alu_add;  // address and upper-immediate sums
    wb_sel     = wb_alu;
    imm        = imm_i;
    case (opcode)
      opc_op: begin
        wen        = 1'b1;
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        alu_op     = alu_decode(funct3, alt);
      end
      opc_op_imm: begin
        wen        = 1'b1;
        o_rs1_used = 1'b1;
        alu_op     = alu_decode(funct3, alt && (funct3 == 3'b101));  // there is no subi
      end
      opc_lui, opc_auipc: begin
        wen = 1'b1;
        imm = imm_u;
      end
      opc_load: begin
        wen        = 1'b1;
        ren_mem    = 1'b1;
        o_rs1_used = 1'b1;
        wb_sel     = wb_load;
      end
      opc_store: begin
        wen_mem    = 1'b1;
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        imm        = imm_s;
      end
      opc_branch: begin
        branch     = 1'b1;
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        imm        = imm_b;
      end
      opc_jal: begin
        wen    = 1'b1;
        jal    = 1'b1;
        wb_sel = wb_pc4;
        imm    = imm_j;
      end
      opc_jalr: begin
        wen        = 1'b1;
        jalr       = 1'b1;
        o_rs1_used = 1'b1;
        wb_sel     = wb_pc4;
      end
      default: ;  // ebreak and unknown opcodes write nothing
    endcase
  end

  // stall, flush and an empty slot all leave a bubble in execute
  always_ff @(posedge i_clk) begin
    if (i_rst || i_stall || i_flush || !i_valid) begin
      o_ex_valid   <= 1'b0;
      o_ex_wen     <= 1'b0;
      o_ex_ren_mem <= 1'b0;
      o_ex_wen_mem <= 1'b0;
      o_ex_branch  <= 1'b0;
      o_ex_jal     <= 1'b0;
      o_ex_jalr    <= 1'b0;
      o_ex_halt    <= 1'b0;
    end else begin
      o_ex_valid   <= 1'b1;
      o_ex_wen     <= wen;
      o_ex_ren_mem <= ren_mem;
      o_ex_wen_mem <= wen_mem;
      o_ex_branch  <= branch;
      o_ex_jal     <= jal;
      o_ex_jalr    <= jalr;
      o_ex_halt    <= (i_inst == EBREAK_INST);
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_pc         <= i_pc;
    o_ex_inst       <= i_inst;
    // lui adds its immediate to zero, auipc adds it to the pc
    o_ex_op1        <= (opcode == opc_lui) ? '0 : (opcode == opc_auipc) ? i_pc : i_rs1_data;
    o_ex_op2        <= (opcode == opc_op || opcode == opc_branch) ? i_rs2_data : imm;
    o_ex_store_data <= i_rs2_data;
    o_ex_imm        <= imm;
    o_ex_rd         <= wen ? i_inst[11:7] : 5'd0;  // stores and branches report rd zero
    o_ex_alu_op     <= alu_op;
    o_ex_wb_sel     <= wb_sel;
    o_ex_funct3     <= funct3;
  end

endmodule

`default_nettype wire

//--- hw/decode/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire hart_pkg::reg_addr_t i_rs1_raddr,
  input  wire hart_pkg::reg_addr_t i_rs2_raddr,
  input  wire hart_pkg::reg_addr_t i_rd_waddr,
  input  wire logic                i_rd_wen,
  input  wire hart_pkg::word_t     i_rd_wdata,
  output hart_pkg::word_t          o_rs1_rdata,
  output hart_pkg::word_t          o_rs2_rdata
);
  import hart_pkg::*;

  word_t regs [32];
  logic  wr_hit;  // a real write, x0 excluded

  assign wr_hit = i_rd_wen && (i_rd_waddr != 5'd0);

  // a read of the register being written sees the new value in the same cycle
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == 5'd0) return '0;
    if (wr_hit && (addr == i_rd_waddr)) return i_rd_wdata;
    return regs[addr];
  endfunction

  assign o_rs1_rdata = read_port(i_rs1_raddr);
  assign o_rs2_rdata = read_port(i_rs2_raddr);

  always_ff @(posedge i_clk) begin
    if (!i_rst && wr_hit) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
  input  wire hart_pkg::reg_addr_t i_rs1,
  input  wire hart_pkg::reg_addr_t i_rs2,
  input  wire logic                i_rs1_used,
  input  wire logic                i_rs2_used,
  input  wire logic                i_id_valid,
  input  wire hart_pkg::reg_addr_t i_ex_rd,   // producer now in execute
  input  wire logic                i_ex_wen,  // already low for bubbles
  input  wire hart_pkg::reg_addr_t i_mem_rd,  // producer now in memory
  input  wire logic                i_mem_wen,
  output logic                     o_stall
);

  logic rs1_hit;
  logic rs2_hit;

  // x0 never carries a dependency, and writeback is covered by the register file bypass
  assign rs1_hit = i_rs1_used && (i_rs1 != 5'd0) &&
                   ((i_ex_wen && (i_ex_rd == i_rs1)) || (i_mem_wen && (i_mem_rd == i_rs1)));
  assign rs2_hit = i_rs2_used && (i_rs2 != 5'd0) &&
                   ((i_ex_wen && (i_ex_rd == i_rs2)) || (i_mem_wen && (i_mem_rd == i_rs2)));

  assign o_stall = i_id_valid && (rs1_hit || rs2_hit);  // an empty decode slot waits for nothing

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
  parameter hart_pkg::word_t RESET_ADDR = '0
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire logic            i_stall,        // decode holds its instruction
  input  wire logic            i_redirect,     // taken branch or jump in execute
  input  wire hart_pkg::word_t i_redirect_pc,
  input  wire hart_pkg::word_t i_imem_rdata,
  output hart_pkg::word_t      o_imem_raddr,
  output hart_pkg::word_t      o_id_pc,
  output hart_pkg::word_t      o_id_inst,
  output logic                 o_id_valid
);
  import hart_pkg::*;

  word_t pc;  // address fetched in this cycle

  assign o_imem_raddr = pc;  // instruction memory answers combinationally

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= RESET_ADDR;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;  // redirect takes priority over a stall
    end else if (!i_stall) begin
      pc <= pc + 32'd4;
    end
  end

  // the word fetched on the wrong path is dropped when execute redirects
  always_ff @(posedge i_clk) begin
    if (i_rst || i_redirect) begin
      o_id_valid <= 1'b0;
    end else if (!i_stall) begin
      o_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_id_pc   <= pc;
      o_id_inst <= i_imem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- common/hart_pkg.sv
`default_nettype none

package hart_pkg;

  localparam int XLEN = 32;  // data and address width

  typedef logic [XLEN-1:0] word_t;  // one data or address word
  typedef logic [4:0] reg_addr_t;  // register number, x0 to x31

  // major opcodes the core executes, everything else decodes as a no-op
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_system = 7'b1110011  // only ebreak is recognised here
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  // source of the value written back to rd
  typedef enum logic [1:0] {
    wb_alu,   // alu result, also covers lui and auipc
    wb_load,  // word returned by data memory
    wb_pc4    // return address of jal and jalr
  } wb_sel_e;

  localparam word_t EBREAK_INST = 32'h00100073;  // halts the program

endpackage

`default_nettype wire
